// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= fetch_stream_tb
FILELIST ?= fetch_stream.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the pass message shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== fetch_stream.f ====
hdl/fetch_stream_pkg.sv
hdl/stream_if.sv
hdl/lfsr27.sv
hdl/stream_table.sv
hdl/stream_chooser.sv
hdl/fetch_issuer.sv
hdl/fetch_stream_top.sv
testbench/fetch_stream_tb.sv

// ==== hdl/fetch_issuer.sv ====
module fetch_issuer
	import fetch_stream_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  pc_stream_t act_stream,
	input  logic credit_return,
	stream_if.issuer strm,
	output logic fetch_valid,
	output logic [STREAM_BITS-1:0] fetch_stream,
	output pc_address_t fetch_pc
);

	logic [CREDIT_BITS-1:0] credits;
	logic issue;

	// ========================================
	// Issue decision
	// ========================================

	// A credit coming back this cycle can be spent right away
	assign issue = act_stream.valid && strm.strm_bitmap[act_stream.stream] &&
		((credits != '0) || credit_return);

	// The table steps the stream address at the same edge the request registers
	assign strm.adv_valid = issue;
	assign strm.adv_stream = act_stream.stream;

	// Credits go down by one per issue and up by one per return
	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= CREDIT_BITS'(CREDITS);
		end else begin
			case ({issue, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// ========================================
	// Request register
	// ========================================

	always_ff @(posedge clk) begin
		if (rst)
			fetch_valid <= 1'b0;
		else
			fetch_valid <= issue;
	end

	// Address before the advance, only loaded when a request goes out
	always_ff @(posedge clk) begin
		if (issue) begin
			fetch_stream <= act_stream.stream;
			fetch_pc <= strm.pcs[act_stream.stream];
		end
	end

	// The cache never holds more requests than there are credits
	a_credit_range: assert property (@(posedge clk) disable iff (rst)
		credits <= CREDIT_BITS'(CREDITS));

	// A return with nothing outstanding would push the count past full
	a_no_extra_return: assert property (@(posedge clk) disable iff (rst)
		(credit_return && !issue) |-> (credits != CREDIT_BITS'(CREDITS)));

endmodule

// ==== hdl/fetch_stream_pkg.sv ====
package fetch_stream_pkg;

	// ========================================
	// Sizing of the fetch stream block
	// ========================================

	// Four hardware threads with a primary and an alternate stream each
	localparam int THREADS = 4;
	localparam int XSTREAMS = 2;
	localparam int NSTREAMS = THREADS * XSTREAMS;
	localparam int STREAM_BITS = $clog2(NSTREAMS);

	// Fetch addresses advance by one fetch block per issued request
	localparam int PC_BITS = 32;
	localparam int FETCH_BYTES = 16;

	// The probability of a thread is one byte compared against the LFSR
	localparam int PROB_BITS = 8;

	// Requests in flight to the instruction cache are limited by credits
	localparam int CREDITS = 4;
	localparam int CREDIT_BITS = $clog2(CREDITS + 1);

	// Galois LFSR for x^27 + x^5 + x^2 + x + 1, shifting toward bit 0
	localparam int LFSR_BITS = 27;
	localparam logic [LFSR_BITS-1:0] LFSR_SEED = 27'h1;
	localparam logic [LFSR_BITS-1:0] LFSR_TAPS = 27'h400_0013;

	// ========================================
	// Types
	// ========================================

	// Names the active stream, valid low means no stream is active
	typedef struct packed {
		logic valid;
		logic [STREAM_BITS-1:0] stream;
	} pc_stream_t;

	typedef logic [PC_BITS-1:0] pc_address_t;

	// Commands from outside logic that edit the stream table
	typedef enum logic [1:0] {
		CMD_NONE = 2'd0,
		CMD_SET = 2'd1,
		CMD_KILL = 2'd2
	} stream_cmd_e;

endpackage

// ==== hdl/fetch_stream_top.sv ====
module fetch_stream_top
	import fetch_stream_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic [THREADS-1:0][PROB_BITS-1:0] thread_probability,
	input  logic is_buffered,
	input  logic cmd_valid,
	input  stream_cmd_e cmd_kind,
	input  logic [STREAM_BITS-1:0] cmd_stream,
	input  pc_address_t cmd_pc,
	input  logic credit_return,
	output logic fetch_valid,
	output logic [STREAM_BITS-1:0] fetch_stream,
	output pc_address_t fetch_pc,
	output pc_stream_t act_stream
);

	// Stream state shared by the table, chooser and issuer
	stream_if strm ();

	// ========================================
	// Stream table
	// ========================================

	stream_table stream_table_i (
		.clk        (clk),
		.rst        (rst),
		.cmd_valid  (cmd_valid),
		.cmd_kind   (cmd_kind),
		.cmd_stream (cmd_stream),
		.cmd_pc     (cmd_pc),
		.strm       (strm.tbl)
	);

	// Picks the active stream from the enabled ones
	stream_chooser stream_chooser_i (
		.clk                (clk),
		.rst                (rst),
		.thread_probability (thread_probability),
		.is_buffered        (is_buffered),
		.strm               (strm.chooser),
		.act_stream         (act_stream)
	);

	// Sends requests for the active stream while credits last
	fetch_issuer fetch_issuer_i (
		.clk           (clk),
		.rst           (rst),
		.act_stream    (act_stream),
		.credit_return (credit_return),
		.strm          (strm.issuer),
		.fetch_valid   (fetch_valid),
		.fetch_stream  (fetch_stream),
		.fetch_pc      (fetch_pc)
	);

endmodule

// ==== hdl/lfsr27.sv ====
module lfsr27
	import fetch_stream_pkg::*;
(
	input  logic clk,
	input  logic rst,
	output logic [LFSR_BITS-1:0] lfsr_out
);

	logic feedback;
	logic [LFSR_BITS-1:0] shifted;

	// Bit 0 leaves the register and folds back into the tap positions
	assign feedback = lfsr_out[0];
	assign shifted = {1'b0, lfsr_out[LFSR_BITS-1:1]};

	// One step per clock, never reaching the all-zero lock-up state
	// as long as the seed is nonzero
	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr_out <= LFSR_SEED;
		end else if (feedback) begin
			lfsr_out <= shifted ^ LFSR_TAPS;
		end else begin
			lfsr_out <= shifted;
		end
	end

	// An all-zero register would freeze the stream selection
	a_lfsr_nonzero: assert property (@(posedge clk) disable iff (rst)
		lfsr_out != '0);

endmodule

// ==== hdl/stream_chooser.sv ====
module stream_chooser
	import fetch_stream_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic [THREADS-1:0][PROB_BITS-1:0] thread_probability,
	input  logic is_buffered,
	stream_if.chooser strm,
	output pc_stream_t act_stream
);

	logic [LFSR_BITS-1:0] lfsr_val;
	logic [PROB_BITS-1:0] rnd;
	pc_stream_t pick;

	// Free running random source, one new word every cycle
	lfsr27 lfsr27_i (
		.clk      (clk),
		.rst      (rst),
		.lfsr_out (lfsr_val)
	);

	// Only the low byte takes part in the probability compare
	assign rnd = lfsr_val[PROB_BITS-1:0];

	// ========================================
	// Selection of the next active stream
	// ========================================

	// Streams are scanned in index order and a later winner replaces an earlier one
	// A zero probability keeps a thread from ever being picked here
	always_comb begin
		pick = '0;
		for (int i = 0; i < NSTREAMS; i++) begin
			// Any enabled stream of a thread can win at an eighth of the probability,
			// but only while fetch comes from a fetch buffer and not the cache
			if (is_buffered && strm.strm_bitmap[i] &&
				(rnd < (thread_probability[i / XSTREAMS] >> 3))) begin
				pick.valid = 1'b1;
				pick.stream = STREAM_BITS'(i);
			end
			// Primary path at full probability, overriding the alternate win above
			if ((i % XSTREAMS) == 0 && strm.strm_bitmap[i] &&
				(rnd < thread_probability[i / XSTREAMS])) begin
				pick.valid = 1'b1;
				pick.stream = STREAM_BITS'(i);
			end
		end
		// No winner, so stay on the current stream while it is still enabled
		if (!pick.valid && act_stream.valid && strm.strm_bitmap[act_stream.stream])
			pick = act_stream;
	end

	always_ff @(posedge clk) begin
		if (rst)
			act_stream <= '0;
		else
			act_stream <= pick;
	end

	// The registered choice refers to a stream that was enabled one cycle earlier
	a_act_enabled: assert property (@(posedge clk) disable iff (rst)
		act_stream.valid |->
			((($past(strm.strm_bitmap) >> act_stream.stream) & NSTREAMS'(1)) != '0));

endmodule

// ==== hdl/stream_if.sv ====
interface stream_if
	import fetch_stream_pkg::*;
();

	// One enable bit per stream, bit n belongs to stream n
	logic [NSTREAMS-1:0] strm_bitmap;

	// Current fetch address of every stream
	pc_address_t [NSTREAMS-1:0] pcs;

	// Advance request, the named stream steps by one fetch block
	logic adv_valid;
	logic [STREAM_BITS-1:0] adv_stream;

	// The table owns the stream state and applies advances
	modport tbl (output strm_bitmap, output pcs, input adv_valid, input adv_stream);

	// The chooser only looks at which streams are enabled
	modport chooser (input strm_bitmap);

	// The issuer reads addresses and asks for the advance
	modport issuer (input pcs, input strm_bitmap, output adv_valid, output adv_stream);

endinterface

// ==== hdl/stream_table.sv ====
module stream_table
	import fetch_stream_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic cmd_valid,
	input  stream_cmd_e cmd_kind,
	input  logic [STREAM_BITS-1:0] cmd_stream,
	input  pc_address_t cmd_pc,
	stream_if.tbl strm
);

	logic [NSTREAMS-1:0] bitmap_q;
	pc_address_t [NSTREAMS-1:0] pcs_q;
	logic [NSTREAMS-1:0] cmd_hit;
	logic [NSTREAMS-1:0] adv_hit;

	// ========================================
	// Decode of commands and advances
	// ========================================

	// One-hot views of which stream the command and the advance target
	always_comb begin
		for (int i = 0; i < NSTREAMS; i++) begin
			cmd_hit[i] = cmd_valid && (cmd_stream == STREAM_BITS'(i));
			adv_hit[i] = strm.adv_valid && (strm.adv_stream == STREAM_BITS'(i));
		end
	end

	// ========================================
	// Stream state
	// ========================================

	// Enable bits change only on commands
	always_ff @(posedge clk) begin
		if (rst) begin
			bitmap_q <= '0;
		end else begin
			for (int i = 0; i < NSTREAMS; i++) begin
				if (cmd_hit[i] && cmd_kind == CMD_SET)
					bitmap_q[i] <= 1'b1;
				else if (cmd_hit[i] && cmd_kind == CMD_KILL)
					bitmap_q[i] <= 1'b0;
			end
		end
	end

	// Fetch addresses
	// A command to a stream wins over an advance of that stream in the same cycle,
	// so a kill also drops the advance and leaves the address where it was
	always_ff @(posedge clk) begin
		for (int i = 0; i < NSTREAMS; i++) begin
			if (cmd_hit[i]) begin
				if (cmd_kind == CMD_SET)
					pcs_q[i] <= cmd_pc;
			end else if (adv_hit[i]) begin
				pcs_q[i] <= pcs_q[i] + PC_BITS'(FETCH_BYTES);
			end
		end
	end

	assign strm.strm_bitmap = bitmap_q;
	assign strm.pcs = pcs_q;

	// A valid command must be a set or a kill because any command blocks the advance of its stream
	a_cmd_known: assert property (@(posedge clk) disable iff (rst)
		cmd_valid |-> (cmd_kind == CMD_SET || cmd_kind == CMD_KILL));

endmodule

// ==== testbench/fetch_stream_tb.sv ====
module fetch_stream_tb
	import fetch_stream_pkg::*;
();

	localparam int PERIOD = 100;
	localparam int LEN_RESET = 40;
	localparam int LEN_ADDR = 300;
	localparam int LEN_CHOOSE = 600;
	localparam int LEN_ALT = 300;
	localparam int LEN_ZERO = 300;
	localparam int LEN_CREDIT = 400;
	localparam int TOTAL = LEN_RESET + LEN_ADDR + LEN_CHOOSE + LEN_ALT + LEN_ZERO + LEN_CREDIT;
	// x^27 + x^5 + x^2 + x + 1, the term x^k sits at bit k-1 of a right shifting register
	localparam logic [LFSR_BITS-1:0] POLY_MASK = (27'h1 << 26) | (27'h1 << 4) | (27'h1 << 1) | 27'h1;

	logic clk, rst, is_buffered, cmd_valid, credit_return, fetch_valid;
	logic [THREADS-1:0][PROB_BITS-1:0] thread_probability;
	stream_cmd_e cmd_kind;
	logic [STREAM_BITS-1:0] cmd_stream, fetch_stream;
	pc_address_t cmd_pc, fetch_pc;
	pc_stream_t act_stream;

	// Reference model state, plus the cache with its queue of pending credit returns
	integer seed = 32'hfd6f;
	logic [NSTREAMS-1:0] m_bitmap;
	pc_address_t m_pcs [NSTREAMS];
	logic [LFSR_BITS-1:0] m_lfsr;
	pc_stream_t m_act, prev_act;
	logic exp_fv;
	logic [STREAM_BITS-1:0] exp_fs;
	pc_address_t exp_pc;
	int returns_q[$];
	int kill_at [NSTREAMS];
	int m_credits, cycle, test_step, issued, outstanding, errors, checks, test_errors;
	// Knobs that shape the stimulus of the running test
	int prelude, zero_thread, cmd_rate, ret_delay;
	bit returns_on, buffered_low;

	fetch_stream_top fetch_stream_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Ends a run that stops making progress
	initial begin
		#((TOTAL + 60) * PERIOD);
		$display("watchdog expired before the last test finished");
		$display("Regression failed");
		$finish;
	end

	// ========================================
	// Model of the LFSR and the chooser
	// ========================================

	function automatic logic [LFSR_BITS-1:0] lfsr_next(logic [LFSR_BITS-1:0] x);
		return x[0] ? ((x >> 1) ^ POLY_MASK) : (x >> 1);
	endfunction

	// Index order scan, alternate test first so a primary win in the same slot replaces it
	function automatic pc_stream_t choose_stream(logic [PROB_BITS-1:0] rnd);
		pc_stream_t win;
		logic [PROB_BITS-1:0] limit;
		win = '0;
		for (int s = 0; s < NSTREAMS; s++) begin
			limit = thread_probability[s / XSTREAMS];
			if (m_bitmap[s] && (is_buffered || (s % XSTREAMS == 0 && rnd < limit)) &&
				(rnd < (limit >> 3) || (s % XSTREAMS == 0 && rnd < limit))) begin
				win.valid = 1'b1;
				win.stream = STREAM_BITS'(s);
			end
		end
		if (!win.valid && m_act.valid && m_bitmap[m_act.stream])
			win = m_act;
		return win;
	endfunction

	// ========================================
	// Compare tasks
	// ========================================

	task automatic check_flag(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_stream(string name, pc_stream_t got, pc_stream_t exp);
		checks++;
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_addr(string name, pc_address_t got, pc_address_t exp);
		checks++;
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic report_failure(string what);
		$display("cycle %0d: %s", cycle, what);
		test_errors++;
	endtask

	// ========================================
	// One clock cycle: compare, drive, then step the model
	// ========================================

	task automatic run_cycle();
		logic ret;
		logic issue;
		pc_stream_t nxt;
		check_flag("fetch_valid", fetch_valid, exp_fv);
		if (exp_fv) begin
			check_stream("fetch_stream", {1'b1, fetch_stream}, {1'b1, exp_fs});
			check_addr("fetch_pc", fetch_pc, exp_pc);
			outstanding++;
			returns_q.push_back(cycle + 1 + int'({$random(seed)} % ret_delay));
		end
		check_stream("act_stream", act_stream, m_act);
		if (fetch_valid === 1'b1) begin
			issued++;
			if (buffered_low && test_step > 6 && fetch_stream[0])
				report_failure("an alternate stream issued while is_buffered was low");
			if (kill_at[fetch_stream] >= 0 && cycle > kill_at[fetch_stream] + 1)
				report_failure("a killed stream kept issuing");
		end
		if (outstanding > CREDITS)
			report_failure("more requests outstanding than there are credits");
		if (zero_thread >= 0 && test_step > 0 && act_stream.valid && act_stream !== prev_act &&
			int'(act_stream.stream) / XSTREAMS == zero_thread)
			report_failure("a thread with zero probability became active");
		prev_act = act_stream;

		// The cache hands credits back in order once their delay has run out
		ret = returns_on && returns_q.size() > 0 && returns_q[0] <= cycle;
		if (ret) begin
			void'(returns_q.pop_front());
			outstanding--;
		end
		credit_return = ret;
		is_buffered = buffered_low ? 1'b0 : 1'($random(seed));
		for (int t = 0; t < THREADS; t++)
			thread_probability[t] = (t == zero_thread) ? '0 :
				(prelude == 1) ? 8'hff : PROB_BITS'($random(seed));
		cmd_valid = int'({$random(seed)} % 16) < cmd_rate;
		cmd_kind = ({$random(seed)} % 3 == 0) ? CMD_KILL : CMD_SET;
		cmd_stream = STREAM_BITS'($random(seed));
		cmd_pc = pc_address_t'($random(seed)) & ~pc_address_t'(FETCH_BYTES - 1);
		// Fixed opening commands, either enabling every stream or killing the alternates
		if ((prelude == 1 && test_step < NSTREAMS) || (prelude == 2 && test_step < THREADS)) begin
			cmd_valid = 1'b1;
			cmd_kind = (prelude == 1) ? CMD_SET : CMD_KILL;
			cmd_stream = (prelude == 1) ? STREAM_BITS'(test_step) : STREAM_BITS'(2 * test_step + 1);
		end
		if (cmd_valid)
			kill_at[cmd_stream] = (cmd_kind == CMD_KILL) ? cycle : -1;

		// What the DUT should do at the coming edge
		issue = m_act.valid && m_bitmap[m_act.stream] && (m_credits > 0 || ret);
		exp_fv = issue;
		if (issue) begin
			exp_fs = m_act.stream;
			exp_pc = m_pcs[m_act.stream];
			if (!(cmd_valid && cmd_stream == m_act.stream))
				m_pcs[m_act.stream] = m_pcs[m_act.stream] + FETCH_BYTES;
		end
		m_credits = m_credits + int'(ret) - int'(issue);
		nxt = choose_stream(m_lfsr[PROB_BITS-1:0]);
		if (cmd_valid && cmd_kind == CMD_SET) begin
			m_pcs[cmd_stream] = cmd_pc;
			m_bitmap[cmd_stream] = 1'b1;
		end else if (cmd_valid) begin
			m_bitmap[cmd_stream] = 1'b0;
		end
		m_act = nxt;
		m_lfsr = lfsr_next(m_lfsr);
		cycle++;
		test_step++;
		@(posedge clk);
		#10;
	endtask

	task automatic begin_test();
		test_errors = 0;
		test_step = 0;
		issued = 0;
	endtask

	task automatic end_test(string name);
		errors += test_errors;
		$display("test %s: %0d errors", name, test_errors);
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		rst = 1'b1;
		{is_buffered, cmd_valid, credit_return} = '0;
		thread_probability = '0;
		cmd_kind = CMD_NONE;
		cmd_stream = '0;
		cmd_pc = '0;
		m_bitmap = '0;
		m_lfsr = LFSR_SEED;
		{m_act, prev_act} = '0;
		exp_fv = 1'b0;
		m_credits = CREDITS;
		foreach (kill_at[s])
			kill_at[s] = -1;
		{cycle, outstanding, errors, checks} = '0;
		{zero_thread, cmd_rate, ret_delay} = {-32'sd1, 32'd0, 32'd6};
		repeat (3) @(posedge clk);
		#10;
		rst = 1'b0;

		// All streams on and no credit returns, only the initial credits can issue
		{prelude, returns_on, buffered_low} = {32'd1, 1'b0, 1'b0};
		begin_test();
		repeat (LEN_RESET) run_cycle();
		if (issued != CREDITS)
			report_failure("request count with no credit returns differs from CREDITS");
		end_test("reset_state");

		{prelude, returns_on, cmd_rate} = {32'd0, 1'b1, 32'd6};
		begin_test();
		repeat (LEN_ADDR) run_cycle();
		end_test("address_sequencing");

		cmd_rate = 2;
		begin_test();
		repeat (LEN_CHOOSE) run_cycle();
		end_test("exact_chooser");

		{prelude, buffered_low} = {32'd2, 1'b1};
		begin_test();
		repeat (LEN_ALT) run_cycle();
		end_test("alternate_gating");

		{prelude, buffered_low, zero_thread, cmd_rate} = {32'd0, 1'b0, 32'd0, 32'd3};
		begin_test();
		repeat (LEN_ZERO) run_cycle();
		end_test("zero_prob_and_kill");

		{zero_thread, ret_delay} = {-32'sd1, 32'd14};
		begin_test();
		repeat (LEN_CREDIT) run_cycle();
		end_test("credit_backpressure");

		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule
